// File: bench/sdram_model.sv
`timescale 1ns/1ps

module sdram_model (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 sdram_req,
    input  rom_pkg::sdram_addr_t sdram_addr,
    output logic                 sdram_ack,
    output logic                 data_dst,
    output logic                 data_rdy,
    output rom_pkg::rom_word_t   data_read
);
    import rom_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_ack,
        st_data,
        st_rdy
    } model_state_t;

    model_state_t state;
    int unsigned  seed;
    int unsigned  wait_cnt;
    sdram_addr_t  held_addr;

    function automatic int unsigned lcg_next(input int unsigned s);
        return (s * 32'd1103515245 + 32'd12345) & 32'h7fff_ffff;
    endfunction

    // 1 to 8 cycles from the upper seed bits
    function automatic int unsigned delay_of(input int unsigned s);
        return 32'd1 + ((s >> 16) & 32'd7);
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            seed      <= 32'd98216;
            wait_cnt  <= 32'd0;
            sdram_ack <= 1'b0;
            data_dst  <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
        end else begin
            sdram_ack <= 1'b0;
            data_dst  <= 1'b0;
            data_rdy  <= 1'b0;
            case (state)
                st_idle: begin
                    if (sdram_req) begin
                        seed     <= lcg_next(seed);
                        wait_cnt <= delay_of(lcg_next(seed));
                        state    <= st_ack;
                    end
                end
                st_ack: begin
                    if (wait_cnt <= 32'd1) begin
                        sdram_ack <= 1'b1;
                        held_addr <= sdram_addr;
                        seed      <= lcg_next(seed);
                        wait_cnt  <= delay_of(lcg_next(seed));
                        state     <= st_data;
                    end else begin
                        wait_cnt <= wait_cnt - 32'd1;
                    end
                end
                st_data: begin
                    if (wait_cnt <= 32'd1) begin
                        data_dst <= 1'b1;
                        state    <= st_rdy;
                    end else begin
                        wait_cnt <= wait_cnt - 32'd1;
                    end
                end
                st_rdy: begin
                    // Word arrives one cycle after data_dst
                    data_rdy  <= 1'b1;
                    data_read <= held_addr[15:0] ^ 16'h5a5a;
                    state     <= st_idle;
                end
            endcase
        end
    end

endmodule

// File: bench/tb_rom_game.sv
`timescale 1ns/1ps

module tb_rom_game;
    import game_pkg::*;
    import rom_pkg::*;

    // Three full frames
    localparam int timeout_limit = 3 * int'(h_total) * int'(v_total) * clk_per_pixel;

    typedef enum int {
        sel_lhbl, sel_hinit, sel_hs, sel_vs, sel_vblank,
        sel_req, sel_char_ok, sel_main_ok, sel_obj_ok
    } watch_t;

    logic        clk;
    logic        arst_n;
    logic        downloading;
    logic        main_cs;
    main_addr_t  main_addr;
    logic        main_ok;
    rom_word_t   main_data;
    logic        obj_cs;
    obj_addr_t   obj_addr;
    logic        obj_ok;
    rom_word_t   obj_data;
    char_addr_t  char_addr;
    logic        char_ok;
    rom_word_t   char_data;
    logic        lhbl;
    logic        lvbl;
    logic        hs;
    logic        vs;
    logic        hinit;
    logic        sdram_req;
    sdram_addr_t sdram_addr;
    logic        sdram_ack;
    logic        data_dst;
    logic        data_rdy;
    rom_word_t   data_read;
    int          cycles;

    rom_game_top i_dut (.*);
    sdram_model  i_sdram (.*);

    always #4 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            fail_run($sformatf("timeout: no end of test after %0d cycles", cycles));
        end
    end

    task automatic check_word(input string name, input rom_word_t got, input rom_word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at time %0t: %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input sdram_addr_t got, input sdram_addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at time %0t: %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_char_addr(input string name, input char_addr_t got,
                                   input char_addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at time %0t: %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at time %0t: %s is %b, expected %b",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("mismatch at time %0t: %s is %0d, expected %0d",
                               $time, name, got, exp));
        end
    endtask

    // Word stored at an SDRAM address
    function automatic rom_word_t rom_pattern(input sdram_addr_t a);
        return a[15:0] ^ 16'h5a5a;
    endfunction

    // Char ROM word address at a scan position
    function automatic char_addr_t scan_char_addr(input int v_pos, input int h_pos);
        return char_addr_t'((v_pos / 8) * 256 + ((h_pos % 256) / 8) * 8 + v_pos % 8);
    endfunction

    function automatic logic watched(input watch_t w);
        case (w)
            sel_lhbl:    return lhbl;
            sel_hinit:   return hinit;
            sel_hs:      return hs;
            sel_vs:      return vs;
            sel_vblank:  return !lvbl;
            sel_req:     return sdram_req;
            sel_char_ok: return char_ok;
            sel_main_ok: return main_ok;
            default:     return obj_ok;
        endcase
    endfunction

    // Samples on the falling edge away from the driving edge
    task automatic wait_rise(input watch_t w);
        logic prev;
        @(negedge clk);
        prev = watched(w);
        @(negedge clk);
        while (!watched(w) || prev) begin
            prev = watched(w);
            @(negedge clk);
        end
    endtask

    task automatic count_high(input watch_t w, output int n);
        int c0;
        wait_rise(w);
        c0 = cycles;
        while (watched(w)) begin
            @(negedge clk);
        end
        n = cycles - c0;
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_bit("sdram_req", sdram_req, 1'b0);
        check_bit("main_ok", main_ok, 1'b0);
        check_bit("obj_ok", obj_ok, 1'b0);
        check_bit("lhbl", lhbl, 1'b1);
        check_bit("lvbl", lvbl, 1'b1);
    endtask

    task automatic test_main_fetch(input main_addr_t a);
        @(posedge clk);
        main_cs   <= 1'b1;
        main_addr <= a;
        wait_rise(sel_main_ok);
        check_word("main_data", main_data, rom_pattern(main_offset + sdram_addr_t'(a)));
        // Address hits the cache so no main ROM traffic
        repeat (64) begin
            @(negedge clk);
            check_bit("main_ok", main_ok, 1'b1);
            if (sdram_req && sdram_addr < char_offset) begin
                fail_run("main ROM was fetched again while its address hit the cache");
            end
        end
    endtask

    task automatic test_char_fetch(input int n);
        check_bit("lvbl", lvbl, 1'b1);
        for (int k = 0; k < n; k++) begin
            wait_rise(sel_char_ok);
            check_word("char_data", char_data,
                       rom_pattern(char_offset + sdram_addr_t'(char_addr)));
        end
    endtask

    task automatic test_timing();
        int n;
        int c0;
        count_high(sel_lhbl, n);
        check_count("lhbl high cycles", n, int'(h_active) * clk_per_pixel);
        wait_rise(sel_hinit);
        c0 = cycles;
        wait_rise(sel_hinit);
        check_count("hinit period", cycles - c0, int'(h_total) * clk_per_pixel);
        count_high(sel_hs, n);
        check_count("hs high cycles", n, int'(hs_len) * clk_per_pixel);
    endtask

    task automatic test_download(input main_addr_t a);
        logic prev;
        @(posedge clk);
        downloading <= 1'b1;
        main_addr   <= a;
        @(negedge clk);
        prev = sdram_req;
        repeat (200) begin
            @(negedge clk);
            if (sdram_req && !prev) begin
                fail_run("sdram_req rose while downloading was high");
            end
            prev = sdram_req;
            check_bit("main_ok", main_ok, 1'b0);
        end
        @(posedge clk);
        downloading <= 1'b0;
        wait_rise(sel_main_ok);
        check_word("main_data", main_data, rom_pattern(main_offset + sdram_addr_t'(a)));
    endtask

    task automatic test_priority(input main_addr_t ma, input obj_addr_t oa);
        wait_rise(sel_vblank);
        // Char fetches ended in the blanking of the line before
        check_bit("sdram_req", sdram_req, 1'b0);
        @(posedge clk);
        main_addr <= ma;
        obj_cs    <= 1'b1;
        obj_addr  <= oa;
        wait_rise(sel_req);
        check_addr("sdram_addr", sdram_addr, main_offset + sdram_addr_t'(ma));
        wait_rise(sel_req);
        check_addr("sdram_addr", sdram_addr, obj_offset + sdram_addr_t'(oa));
        if (!obj_ok) begin
            wait_rise(sel_obj_ok);
        end
        check_word("obj_data", obj_data, rom_pattern(obj_offset + sdram_addr_t'(oa)));
        check_word("main_data", main_data, rom_pattern(main_offset + sdram_addr_t'(ma)));
    endtask

    task automatic test_scan_position();
        int px [4];
        int pos;
        int target;
        px = '{0, 47, 206, 300};
        wait_rise(sel_vs);
        // Scan sits at pixel 0 of line vs_start here
        pos = 0;
        for (int line = 0; line < 12; line++) begin
            for (int k = 0; k < 4; k++) begin
                target = line * int'(h_total) + px[k];
                repeat ((target - pos) * clk_per_pixel) @(negedge clk);
                pos = target;
                check_char_addr("char_addr", char_addr,
                                scan_char_addr(int'(vs_start) + line, px[k]));
                check_bit("vs", vs, (line < int'(vs_len)) ? 1'b1 : 1'b0);
                check_bit("char_ok", char_ok, 1'b0);
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        downloading = 1'b0;
        main_cs     = 1'b0;
        main_addr   = '0;
        obj_cs      = 1'b0;
        obj_addr    = '0;
        cycles      = 0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        test_reset();
        test_main_fetch(17'h0_1234);
        test_char_fetch(32);
        test_timing();
        test_download(17'h1_0abc);
        test_priority(17'h0_0777, 17'h1_4321);
        test_scan_position();
        $display("Test OK");
        $finish;
    end

endmodule

// File: list.f
source/game_pkg.sv
source/rom_pkg.sv
source/cen_gen.sv
source/video_scan.sv
source/rom_slot.sv
source/sdram_arbiter.sv
source/rom_game_top.sv
bench/sdram_model.sv
bench/tb_rom_game.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_rom_game -f list.f -o tb_rom_game
./obj_dir/tb_rom_game

// File: source/cen_gen.sv
`timescale 1ns/1ps

module cen_gen (
    input  logic clk,
    input  logic arst_n,
    output logic cen_pxl,
    output logic cen_half
);
    import game_pkg::*;

    logic [2:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt      <= '0;
            cen_pxl  <= 1'b0;
            cen_half <= 1'b0;
        end else begin
            cnt      <= cnt + 1'b1;
            // One pulse per pixel
            cen_pxl  <= (cnt[1:0] == 2'(clk_per_pixel - 1));
            // Every second pixel
            cen_half <= (cnt == 3'(2 * clk_per_pixel - 1));
        end
    end

endmodule

// File: source/game_pkg.sv
package game_pkg;

    // Screen position counters
    typedef logic [8:0] hpos_t;
    typedef logic [8:0] vpos_t;

    // Horizontal timing in pixels
    localparam hpos_t h_total  = 9'd384;
    localparam hpos_t h_active = 9'd256;
    localparam hpos_t hs_start = 9'd288;
    localparam hpos_t hs_len   = 9'd32;

    // Vertical timing in lines
    localparam vpos_t v_total  = 9'd262;
    localparam vpos_t v_active = 9'd224;
    localparam vpos_t vs_start = 9'd232;
    localparam vpos_t vs_len   = 9'd4;

    // Pixel clock is clk divided by this
    localparam int clk_per_pixel = 4;

endpackage

// File: source/rom_game_top.sv
`timescale 1ns/1ps

module rom_game_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 downloading,
    // CPU program ROM
    input  logic                 main_cs,
    input  rom_pkg::main_addr_t  main_addr,
    output logic                 main_ok,
    output rom_pkg::rom_word_t   main_data,
    // Sprite ROM
    input  logic                 obj_cs,
    input  rom_pkg::obj_addr_t   obj_addr,
    output logic                 obj_ok,
    output rom_pkg::rom_word_t   obj_data,
    // Character ROM, addressed by the scan
    output rom_pkg::char_addr_t  char_addr,
    output logic                 char_ok,
    output rom_pkg::rom_word_t   char_data,
    // Video timing
    output logic                 lhbl,
    output logic                 lvbl,
    output logic                 hs,
    output logic                 vs,
    output logic                 hinit,
    // SDRAM port
    output logic                 sdram_req,
    output rom_pkg::sdram_addr_t sdram_addr,
    input  logic                 sdram_ack,
    input  logic                 data_dst,
    input  logic                 data_rdy,
    input  rom_pkg::rom_word_t   data_read
);
    import rom_pkg::*;

    logic      cen_pxl;
    logic      char_cs;
    slot_req_t slot_req [n_slots];
    slot_rsp_t slot_rsp [n_slots];

    cen_gen u_cen (
        .clk      ( clk     ),
        .arst_n   ( arst_n  ),
        .cen_pxl  ( cen_pxl ),
        .cen_half (         )
    );

    video_scan u_scan (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .cen_pxl   ( cen_pxl   ),
        .h         (           ),
        .v         (           ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .hinit     ( hinit     ),
        .char_addr ( char_addr ),
        .char_cs   ( char_cs   )
    );

    rom_slot #(
        .aw     ( $bits(main_addr_t) ),
        .offset ( main_offset        )
    ) u_main (
        .clk         ( clk                 ),
        .arst_n      ( arst_n              ),
        .downloading ( downloading         ),
        .cs          ( main_cs             ),
        .addr        ( main_addr           ),
        .ok          ( main_ok             ),
        .data        ( main_data           ),
        .req         ( slot_req[slot_main] ),
        .rsp         ( slot_rsp[slot_main] )
    );

    rom_slot #(
        .aw     ( $bits(char_addr_t) ),
        .offset ( char_offset        )
    ) u_char (
        .clk         ( clk                 ),
        .arst_n      ( arst_n              ),
        .downloading ( downloading         ),
        .cs          ( char_cs             ),
        .addr        ( char_addr           ),
        .ok          ( char_ok             ),
        .data        ( char_data           ),
        .req         ( slot_req[slot_char] ),
        .rsp         ( slot_rsp[slot_char] )
    );

    rom_slot #(
        .aw     ( $bits(obj_addr_t) ),
        .offset ( obj_offset        )
    ) u_obj (
        .clk         ( clk                ),
        .arst_n      ( arst_n             ),
        .downloading ( downloading        ),
        .cs          ( obj_cs             ),
        .addr        ( obj_addr           ),
        .ok          ( obj_ok             ),
        .data        ( obj_data           ),
        .req         ( slot_req[slot_obj] ),
        .rsp         ( slot_rsp[slot_obj] )
    );

    sdram_arbiter u_arb (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .req         ( slot_req    ),
        .rsp         ( slot_rsp    ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_ack   ( sdram_ack   ),
        .data_dst    ( data_dst    ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   )
    );

endmodule

// File: source/rom_pkg.sv
package rom_pkg;

    // Widths on the SDRAM side
    typedef logic [21:0] sdram_addr_t;
    typedef logic [15:0] rom_word_t;

    // Client word addresses
    typedef logic [13:0] char_addr_t;
    typedef logic [16:0] main_addr_t;
    typedef logic [16:0] obj_addr_t;

    // Request from a slot, address already moved to its ROM region
    typedef struct packed {
        logic        req;
        sdram_addr_t addr;
    } slot_req_t;

    // Data strobe back to a slot
    typedef struct packed {
        logic      valid;
        rom_word_t data;
    } slot_rsp_t;

    // Slot indices, lower index wins
    localparam int n_slots   = 3;
    localparam int slot_main = 0;
    localparam int slot_char = 1;
    localparam int slot_obj  = 2;

    // Where each ROM sits in SDRAM
    localparam sdram_addr_t main_offset = 22'h0_0000;
    localparam sdram_addr_t char_offset = 22'h1_8000;
    localparam sdram_addr_t obj_offset  = 22'h4_c000;

    typedef enum logic [1:0] {
        idle,
        wait_ack,
        wait_data
    } arb_state_t;

endpackage

// File: source/rom_slot.sv
`timescale 1ns/1ps

module rom_slot #(
    parameter int                   aw     = 17,
    parameter rom_pkg::sdram_addr_t offset = '0
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               downloading,
    input  logic               cs,
    input  logic [aw-1:0]      addr,
    output logic               ok,
    output rom_pkg::rom_word_t data,
    output rom_pkg::slot_req_t req,
    input  rom_pkg::slot_rsp_t rsp
);
    import rom_pkg::*;

    logic          cache_valid;
    logic [aw-1:0] cache_addr;
    rom_word_t     cache_data;
    logic          req_on;
    logic [aw-1:0] pend_addr;
    logic          hit;
    logic          miss;
    logic          fill;

    assign hit  = cache_valid && (cache_addr == addr);
    assign miss = cs && !hit && !req_on;
    assign fill = req_on && rsp.valid;

    assign ok   = cs && hit;
    assign data = cache_data;

    // Address is held in pend_addr for the whole request
    assign req.req  = req_on;
    assign req.addr = offset + sdram_addr_t'(pend_addr);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cache_valid <= 1'b0;
            req_on      <= 1'b0;
        end else begin
            if (fill) begin
                req_on      <= 1'b0;
                cache_valid <= 1'b1;
            end else if (miss) begin
                req_on <= 1'b1;
            end
            // ROM contents are changing
            if (downloading) begin
                cache_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            pend_addr <= addr;
        end
        if (fill) begin
            cache_addr <= pend_addr;
            cache_data <= rsp.data;
        end
    end

endmodule

// File: source/sdram_arbiter.sv
`timescale 1ns/1ps

module sdram_arbiter (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 downloading,
    input  rom_pkg::slot_req_t   req [rom_pkg::n_slots],
    output rom_pkg::slot_rsp_t   rsp [rom_pkg::n_slots],
    output logic                 sdram_req,
    output rom_pkg::sdram_addr_t sdram_addr,
    input  logic                 sdram_ack,
    input  logic                 data_dst,
    input  logic                 data_rdy,
    input  rom_pkg::rom_word_t   data_read
);
    import rom_pkg::*;

    typedef logic [$clog2(n_slots)-1:0] idx_t;

    arb_state_t state;
    idx_t       grant;
    idx_t       pick;
    logic       any_req;
    logic       start;
    logic       dst_seen;
    logic       done;

    // Lowest requesting index wins
    always_comb begin
        pick    = '0;
        any_req = 1'b0;
        for (int i = n_slots - 1; i >= 0; i--) begin
            if (req[i].req) begin
                pick    = idx_t'(i);
                any_req = 1'b1;
            end
        end
    end

    assign start = (state == idle) && any_req && !downloading;
    assign done  = (state == wait_data) && data_rdy && (dst_seen || data_dst);

    // Strobe goes to the granted slot only
    always_comb begin
        for (int i = 0; i < n_slots; i++) begin
            rsp[i].valid = done && (grant == idx_t'(i));
            rsp[i].data  = data_read;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= idle;
            grant     <= '0;
            sdram_req <= 1'b0;
            dst_seen  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    dst_seen <= 1'b0;
                    if (start) begin
                        grant     <= pick;
                        sdram_req <= 1'b1;
                        state     <= wait_ack;
                    end
                end
                wait_ack: begin
                    if (data_dst) begin
                        dst_seen <= 1'b1;
                    end
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= wait_data;
                    end
                end
                wait_data: begin
                    if (data_dst) begin
                        dst_seen <= 1'b1;
                    end
                    if (done) begin
                        state <= idle;
                    end
                end
                default: begin
                    state     <= idle;
                    sdram_req <= 1'b0;
                end
            endcase
        end
    end

    // Address is stable from grant until ack
    always_ff @(posedge clk) begin
        if (start) begin
            sdram_addr <= req[pick].addr;
        end
    end

endmodule

// File: source/video_scan.sv
`timescale 1ns/1ps

module video_scan (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                cen_pxl,
    output game_pkg::hpos_t     h,
    output game_pkg::vpos_t     v,
    output logic                lhbl,
    output logic                lvbl,
    output logic                hs,
    output logic                vs,
    output logic                hinit,
    output rom_pkg::char_addr_t char_addr,
    output logic                char_cs
);
    import game_pkg::*;
    import rom_pkg::*;

    hpos_t h_nxt;
    vpos_t v_nxt;
    logic  lhbl_nxt;
    logic  lvbl_nxt;

    // Position after the coming pixel
    always_comb begin
        h_nxt = h + 1'b1;
        v_nxt = v;
        if (h == h_total - 1'b1) begin
            h_nxt = '0;
            if (v == v_total - 1'b1) begin
                v_nxt = '0;
            end else begin
                v_nxt = v + 1'b1;
            end
        end
    end

    assign lhbl_nxt = (h_nxt < h_active);
    assign lvbl_nxt = (v_nxt < v_active);

    // Outputs follow the counters on the same enable
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h         <= '0;
            v         <= '0;
            lhbl      <= 1'b1;
            lvbl      <= 1'b1;
            hs        <= 1'b0;
            vs        <= 1'b0;
            hinit     <= 1'b1;
            char_addr <= '0;
            char_cs   <= 1'b1;
        end else if (cen_pxl) begin
            h     <= h_nxt;
            v     <= v_nxt;
            lhbl  <= lhbl_nxt;
            lvbl  <= lvbl_nxt;
            hs    <= (h_nxt >= hs_start) && (h_nxt < hs_start + hs_len);
            vs    <= (v_nxt >= vs_start) && (v_nxt < vs_start + vs_len);
            hinit <= (h_nxt == '0);
            // Tile row, tile column, line within the tile
            char_addr <= char_addr_t'({v_nxt[7:3], h_nxt[7:3], v_nxt[2:0]});
            char_cs   <= lhbl_nxt & lvbl_nxt;
        end
    end

endmodule
